/* alu/alu.sv */
// RISC-V integer ALU
// Add/sub, signed and unsigned compare, logic ops and shifts.
// Also gives the raw sum for address generation. On RV64 the W-type
// ops have their low 32 bits sign-extended
`timescale 1ns/1ps

module alu #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  execPkg::aluCtrlT aluCtrl,
  input  logic [2:0]       funct3,
  input  logic [6:0]       funct7,  // Only used by bit-manip ops
  output logic [WIDTH-1:0] result,
  output logic [WIDTH-1:0] sum
);

  localparam int SHW = $clog2(WIDTH); // Shift amount width

  logic             w64;        // W-type op
  logic             subArith;   // Sub or sra
  logic             aluOp;      // 0 = forced add
  logic [WIDTH-1:0] condInvB;   // ~b when subtracting
  logic             carry;      // Adder carry out
  logic             neg;        // Sign of a - b
  logic             aSign;
  logic             bSign;
  logic             lt;         // Signed less than
  logic             ltu;        // Unsigned less than
  logic [WIDTH-1:0] shiftY;     // Shifter output
  logic [WIDTH-1:0] fullResult; // Before W sign extension

  assign {w64, subArith, aluOp} = aluCtrl;

  ////////////////////
  // Adder
  ////////////////////
  assign condInvB = subArith ? ~b : b;
  assign {carry, sum} = {1'b0, a} + {1'b0, condInvB} + {{WIDTH{1'b0}}, subArith};

  // Shift amount from low bits of b, funct3[2] picks right
  shifter #(.WIDTH(WIDTH)) sh (
    .a     (a),
    .amt   (b[SHW-1:0]),
    .right (funct3[2]),
    .arith (subArith),
    .w64   (w64),
    .y     (shiftY)
  );

  ////////////////////
  // Compare flags
  ////////////////////
  // Flags from sum = a - b
  assign neg   = sum[WIDTH-1];
  assign aSign = a[WIDTH-1];
  assign bSign = b[WIDTH-1];
  // Signed overflow folded in
  assign lt    = (aSign & ~bSign) | (aSign & neg) | (~bSign & neg);
  assign ltu   = ~carry;  // Borrow

  always_comb begin
    if (!aluOp) begin
      fullResult = sum;   // Address gen, AUIPC, LUI
    end else begin
      case (funct3)
        execPkg::F3_ADD:  fullResult = sum;
        execPkg::F3_SLL:  fullResult = shiftY;
        execPkg::F3_SR:   fullResult = shiftY;
        execPkg::F3_SLT:  fullResult = {{(WIDTH-1){1'b0}}, lt};
        execPkg::F3_SLTU: fullResult = {{(WIDTH-1){1'b0}}, ltu};
        execPkg::F3_XOR:  fullResult = a ^ b;
        execPkg::F3_OR:   fullResult = a | b;
        default:          fullResult = a & b;  // and
      endcase
    end
  end

  // W-type keeps low word, sign-extended
  if (WIDTH == 64) begin : gW64
    assign result = w64 ? {{32{fullResult[31]}}, fullResult[31:0]} : fullResult;
  end else begin : gW32
    assign result = fullResult;
  end

  // Decoder must never pass a W-type op on RV32
  always_comb begin
    if (WIDTH == 32) begin
      assert (w64 !== 1'b1) else $error("alu: w64 set with WIDTH 32");
    end
  end

endmodule

/* alu/shifter.sv */
// Barrel shifter for the ALU
// One right shifter over a double-width operand serves all shifts.
// Left shifts bit-reverse in and out. W-type uses the low word
`timescale 1ns/1ps

module shifter #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0]         a,
  input  logic [$clog2(WIDTH)-1:0] amt,
  input  logic                     right,
  input  logic                     arith,
  input  logic                     w64,
  output logic [WIDTH-1:0]         y
);

  logic [WIDTH-1:0]         aSel;    // Operand after word handling
  logic [$clog2(WIDTH)-1:0] amtSel;
  logic                     signBit; // Fill for sra
  logic [WIDTH-1:0]         aIn;
  logic [2*WIDTH-1:0]       ext;
  logic [2*WIDTH-1:0]       shifted;
  logic [WIDTH-1:0]         yRaw;

  function automatic logic [WIDTH-1:0] bitRev(input logic [WIDTH-1:0] v);
    logic [WIDTH-1:0] r;
    for (int i = 0; i < WIDTH; i++) begin
      r[i] = v[WIDTH-1-i];
    end
    return r;
  endfunction

  if (WIDTH == 64) begin : gWord
    always_comb begin
      if (w64) begin
        aSel   = {{32{arith & a[31]}}, a[31:0]}; // sraw fills with bit 31
        amtSel = {1'b0, amt[4:0]};               // 5-bit amount
      end else begin
        aSel   = a;
        amtSel = amt;
      end
    end
  end else begin : gNoWord
    assign aSel   = a;
    assign amtSel = amt;
  end

  assign signBit = arith & right & aSel[WIDTH-1];
  assign aIn     = right ? aSel : bitRev(aSel);   // Reverse for left
  assign ext     = {{WIDTH{signBit}}, aIn};
  assign shifted = ext >> amtSel;
  assign yRaw    = shifted[WIDTH-1:0];
  assign y       = right ? yRaw : bitRev(yRaw);

endmodule

/* bench/executeUnitTb.sv */
// Testbench for the execute stage
// Random RV64I ALU traffic with a queue-based reference model.
// Concurrent assertions check latency, result, sum and illegal flag
`timescale 1ns/1ps

module executeUnitTb;

  localparam int halfPeriod  = 20;
  localparam int clkPeriod   = 2 * halfPeriod;
  localparam int resetCycles = 5;
  localparam int stimDelay   = 2;  // After the rising edge
  localparam int arithIters  = 10; // 13 ops each
  localparam int shiftIters  = 8;  // 6 ops each
  localparam int wordIters   = 6;  // 6 ops each
  localparam int addrIters   = 4;  // 4 ops each
  localparam int totalInstr  = 5 + 13 * arithIters + 6 * shiftIters + 6 * wordIters
                               + 4 * addrIters + 8;

  logic clk = 1'b0;
  logic rst, inValid;
  logic [6:0] opcode, funct7;
  logic [2:0] funct3;
  logic [63:0] rs1Val, rs2Val, imm, pc;
  logic outValid, outIllegal;
  logic [63:0] outResult, outSum;

  int seed = 36;
  string testName = "reset";

  // Reference queues, one entry per strobe
  logic [63:0] expResQ[$];
  logic chkSumQ[$];
  logic illQ[$];
  string nameQ[$];

  // Stable copies for the assertions, refreshed at the falling edge
  logic [1:0] validHist = 2'b00;
  logic armed = 1'b0;
  logic expValid = 1'b0;
  logic expIllegal = 1'b0;
  logic expChkSum = 1'b0;
  logic actValid = 1'b0;
  logic actIllegal = 1'b0;
  logic [63:0] expResult = '0;
  logic [63:0] actResult = '0;
  logic [63:0] actSum = '0;
  string expName = "none";

  executeUnit #(.WIDTH(64)) uut (
    .clk(clk), .rst(rst), .inValid(inValid), .opcode(opcode), .funct3(funct3),
    .funct7(funct7), .rs1Val(rs1Val), .rs2Val(rs2Val), .imm(imm), .pc(pc),
    .outValid(outValid), .outResult(outResult), .outSum(outSum), .outIllegal(outIllegal)
  );

  always #(halfPeriod) clk = ~clk;

  ////////////////////
  // Model helpers
  ////////////////////
  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [63:0] randImm12(); // Sign-extended I-type immediate
    logic [31:0] r;
    r = $random(seed);
    return {{52{r[11]}}, r[11:0]};
  endfunction

  function automatic logic [63:0] signExt32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] lessSigned(input logic [63:0] x, input logic [63:0] y);
    return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
  endfunction

  function automatic logic [63:0] lessUnsigned(input logic [63:0] x, input logic [63:0] y);
    return (x < y) ? 64'd1 : 64'd0;
  endfunction

  function automatic logic [63:0] shiftRightArith64(input logic [63:0] v, input logic [5:0] s);
    return $signed(v) >>> s;
  endfunction

  function automatic logic [31:0] shiftRightArith32(input logic [31:0] v, input logic [4:0] s);
    return $signed(v) >>> s;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  ////////////////////
  // Stimulus tasks
  ////////////////////
  task automatic issue(input string name, input logic [6:0] opc, input logic [2:0] f3,
                       input logic [6:0] f7, input logic [63:0] r1, input logic [63:0] r2,
                       input logic [63:0] iv, input logic [63:0] pcv,
                       input logic [63:0] expRes, input logic chkSum, input logic expIll);
    @(posedge clk);
    #(stimDelay);
    inValid = 1'b1;
    opcode  = opc;
    funct3  = f3;
    funct7  = f7;
    rs1Val  = r1;
    rs2Val  = r2;
    imm     = iv;
    pc      = pcv;
    expResQ.push_back(expRes);
    chkSumQ.push_back(chkSum);
    illQ.push_back(expIll);
    nameQ.push_back(name);
  endtask

  // Unused operand lanes get noise so the muxes are exercised
  task automatic regOp(input string name, input logic [6:0] opc, input logic [2:0] f3,
                       input logic [6:0] f7, input logic [63:0] r1, input logic [63:0] r2,
                       input logic [63:0] expRes);
    issue(name, opc, f3, f7, r1, r2, rand64(), rand64(), expRes, 1'b0, 1'b0);
  endtask

  task automatic immOp(input string name, input logic [6:0] opc, input logic [2:0] f3,
                       input logic [6:0] f7, input logic [63:0] r1, input logic [63:0] iv,
                       input logic [63:0] expRes);
    issue(name, opc, f3, f7, r1, rand64(), iv, rand64(), expRes, 1'b0, 1'b0);
  endtask

  task automatic badOp(input string name, input logic [6:0] opc, input logic [2:0] f3,
                       input logic [6:0] f7);
    issue(name, opc, f3, f7, rand64(), rand64(), rand64(), rand64(), '0, 1'b0, 1'b1);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #(stimDelay);
      inValid = 1'b0;
    end
  endtask

  ////////////////////
  // Test sequences
  ////////////////////
  task automatic runLatency();
    logic [63:0] a, b;
    testName = "latency";
    idle(2);                                      // outValid must stay low
    for (int k = 0; k < 5; k++) begin
      a = rand64();
      b = rand64();
      regOp("latency add", execPkg::OP_REG, execPkg::F3_ADD, 7'h00, a, b, a + b);
      if (k == 0) idle(1);
      if (k == 1) idle(2);                        // Then three back to back
    end
  endtask

  task automatic runArith();
    logic [63:0] a, b, iv;
    testName = "arith";
    for (int k = 0; k < arithIters; k++) begin
      a  = rand64();
      b  = (k % 4 == 0) ? a : rand64();           // Equal operands now and then
      iv = randImm12();
      regOp("add",  execPkg::OP_REG, execPkg::F3_ADD,  7'h00, a, b, a + b);
      regOp("sub",  execPkg::OP_REG, execPkg::F3_ADD,  7'h20, a, b, a - b);
      regOp("xor",  execPkg::OP_REG, execPkg::F3_XOR,  7'h00, a, b, a ^ b);
      regOp("or",   execPkg::OP_REG, execPkg::F3_OR,   7'h00, a, b, a | b);
      regOp("and",  execPkg::OP_REG, execPkg::F3_AND,  7'h00, a, b, a & b);
      regOp("slt",  execPkg::OP_REG, execPkg::F3_SLT,  7'h00, a, b, lessSigned(a, b));
      regOp("sltu", execPkg::OP_REG, execPkg::F3_SLTU, 7'h00, a, b, lessUnsigned(a, b));
      immOp("addi", execPkg::OP_IMM, execPkg::F3_ADD, iv[11:5], a, iv, a + iv);
      immOp("xori", execPkg::OP_IMM, execPkg::F3_XOR, iv[11:5], a, iv, a ^ iv);
      immOp("ori",  execPkg::OP_IMM, execPkg::F3_OR,  iv[11:5], a, iv, a | iv);
      immOp("andi", execPkg::OP_IMM, execPkg::F3_AND, iv[11:5], a, iv, a & iv);
      immOp("slti", execPkg::OP_IMM, execPkg::F3_SLT, iv[11:5], a, iv, lessSigned(a, iv));
      immOp("sltiu", execPkg::OP_IMM, execPkg::F3_SLTU, iv[11:5], a, iv,
            lessUnsigned(a, iv));
    end
  endtask

  task automatic runShifts();
    logic [63:0] a, n, r, sh;
    logic [5:0] amt;
    testName = "shift";
    for (int k = 0; k < shiftIters; k++) begin
      a   = rand64();
      n   = {1'b1, a[62:0]};                      // Negative for sra
      r   = rand64();
      amt = (k == 0) ? 6'd0 : (k == 1) ? 6'd63 : r[5:0];
      sh  = {r[63:6], amt};                       // Upper rs2 bits are noise
      regOp("sll", execPkg::OP_REG, execPkg::F3_SLL, 7'h00, a, sh, a << amt);
      regOp("srl", execPkg::OP_REG, execPkg::F3_SR,  7'h00, a, sh, a >> amt);
      regOp("sra", execPkg::OP_REG, execPkg::F3_SR,  7'h20, n, sh, shiftRightArith64(n, amt));
      immOp("slli", execPkg::OP_IMM, execPkg::F3_SLL, {6'h00, amt[5]}, a, {58'd0, amt},
            a << amt);
      immOp("srli", execPkg::OP_IMM, execPkg::F3_SR, {6'h00, amt[5]}, a, {58'd0, amt},
            a >> amt);
      immOp("srai", execPkg::OP_IMM, execPkg::F3_SR, {6'h10, amt[5]}, n,
            {52'd0, 6'h10, amt}, shiftRightArith64(n, amt));
    end
  endtask

  task automatic runWord();
    logic [63:0] a, b, iv;
    testName = "word";
    for (int k = 0; k < wordIters; k++) begin
      a  = rand64();
      a  = k[0] ? (a | 64'h8000_0000) : a;        // Negative low word on odd passes
      b  = rand64();
      iv = randImm12();
      regOp("addw", execPkg::OP_REG32, execPkg::F3_ADD, 7'h00, a, b,
            signExt32(a[31:0] + b[31:0]));
      regOp("subw", execPkg::OP_REG32, execPkg::F3_ADD, 7'h20, a, b,
            signExt32(a[31:0] - b[31:0]));
      regOp("sllw", execPkg::OP_REG32, execPkg::F3_SLL, 7'h00, a, b,
            signExt32(a[31:0] << b[4:0]));
      regOp("srlw", execPkg::OP_REG32, execPkg::F3_SR, 7'h00, a, b,
            signExt32(a[31:0] >> b[4:0]));
      regOp("sraw", execPkg::OP_REG32, execPkg::F3_SR, 7'h20, a, b,
            signExt32(shiftRightArith32(a[31:0], b[4:0])));
      immOp("addiw", execPkg::OP_IMM32, execPkg::F3_ADD, iv[11:5], a, iv,
            signExt32(a[31:0] + iv[31:0]));
    end
  endtask

  task automatic runAddrGen();
    logic [63:0] a, iv, p, r, u;
    testName = "addrgen";
    for (int k = 0; k < addrIters; k++) begin
      a  = rand64();
      iv = randImm12();
      p  = rand64();
      r  = rand64();
      u  = {{32{r[31]}}, r[31:12], 12'h000};     // U-type immediate
      issue("load", execPkg::OP_LOAD, 3'b011, iv[11:5], a, rand64(), iv, p, a + iv,
            1'b1, 1'b0);
      issue("store", execPkg::OP_STORE, 3'b011, iv[11:5], a, rand64(), iv, p, a + iv,
            1'b1, 1'b0);
      issue("auipc", execPkg::OP_AUIPC, u[14:12], u[31:25], a, rand64(), u, p, p + u,
            1'b1, 1'b0);
      issue("lui", execPkg::OP_LUI, u[14:12], u[31:25], a, rand64(), u, p, u, 1'b1, 1'b0);
    end
  endtask

  task automatic runIllegal();
    logic [63:0] a, b;
    testName = "illegal";
    a = rand64();
    b = rand64();
    badOp("bad opcode", 7'b1111111, execPkg::F3_ADD, 7'h00);
    regOp("add after illegal", execPkg::OP_REG, execPkg::F3_ADD, 7'h00, a, b, a + b);
    badOp("fence opcode", 7'b0001111, execPkg::F3_ADD, 7'h00);
    regOp("add after illegal", execPkg::OP_REG, execPkg::F3_ADD, 7'h00, a, b, a + b);
    badOp("mul funct7", execPkg::OP_REG, execPkg::F3_ADD, 7'h01);
    regOp("or after illegal", execPkg::OP_REG, execPkg::F3_OR, 7'h00, a, b, a | b);
    badOp("xor alt funct7", execPkg::OP_REG, execPkg::F3_XOR, 7'h20);
    regOp("xor after illegal", execPkg::OP_REG, execPkg::F3_XOR, 7'h00, a, b, a ^ b);
  endtask

  ////////////////////
  // Checking
  ////////////////////
  always @(posedge clk) validHist <= {validHist[0], inValid}; // Strobe seen two edges back

  always @(negedge clk) begin
    armed      = 1'b1;                            // First falling edge follows a reset edge
    expValid   = validHist[1];
    actValid   = outValid;
    actResult  = outResult;
    actSum     = outSum;
    actIllegal = outIllegal;
    if (outValid && expResQ.size() > 0) begin
      expResult  = expResQ.pop_front();
      expChkSum  = chkSumQ.pop_front();
      expIllegal = illQ.pop_front();
      expName    = nameQ.pop_front();
    end
  end

  validCheck: assert property (@(posedge clk) armed |-> actValid == expValid)
    else abortRun($sformatf("MISMATCH %s outValid: expected %0b actual %0b",
                            testName, expValid, actValid));

  illegalCheck: assert property (@(posedge clk) armed && actValid |-> actIllegal == expIllegal)
    else abortRun($sformatf("MISMATCH %s outIllegal: expected %0b actual %0b",
                            expName, expIllegal, actIllegal));

  // Result is don't-care on illegal beats
  resultCheck: assert property (@(posedge clk)
                                armed && actValid && !expIllegal |-> actResult == expResult)
    else abortRun($sformatf("MISMATCH %s outResult: expected %h actual %h",
                            expName, expResult, actResult));

  sumCheck: assert property (@(posedge clk) armed && actValid && expChkSum |-> actSum == expResult)
    else abortRun($sformatf("MISMATCH %s outSum: expected %h actual %h",
                            expName, expResult, actSum));

  // Watchdog sized from the instruction count
  initial begin
    #((totalInstr + 20) * clkPeriod);
    abortRun("Timeout: instructions did not all retire in time");
  end

  initial begin
    rst     = 1'b1;
    inValid = 1'b0;
    opcode  = '0;
    funct3  = '0;
    funct7  = '0;
    rs1Val  = '0;
    rs2Val  = '0;
    imm     = '0;
    pc      = '0;
    repeat (resetCycles) @(posedge clk);
    #(stimDelay);
    rst = 1'b0;
    runLatency();
    runArith();
    runShifts();
    runWord();
    runAddrGen();
    runIllegal();
    idle(1);
    while (expResQ.size() != 0) @(posedge clk);
    idle(2);                                      // No stray outValid after drain
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* common/execPkg.sv */
// Execute stage shared definitions
// ALU control bits, funct3 and opcode codes, operand select encodings
package execPkg;

  ////////////////////
  // ALU control
  ////////////////////
  typedef struct packed {
    logic w64;      // RV64 W-type op
    logic subArith; // Subtract or arithmetic right shift
    logic aluOp;    // 0 forces add
  } aluCtrlT;

  ////////////////////
  // Funct3 codes
  ////////////////////
  localparam logic [2:0] F3_ADD  = 3'b000; // add/sub, also addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl or sra, picked by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  ////////////////////
  // Opcodes
  ////////////////////
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG32 = 7'b0111011; // RV64 only
  localparam logic [6:0] OP_IMM32 = 7'b0011011; // RV64 only
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_LUI   = 7'b0110111;

  // Operand sources
  typedef enum logic [1:0] {SRC_A_REG = 2'd0, SRC_A_PC = 2'd1, SRC_A_ZERO = 2'd2} srcASelT;
  typedef enum logic {SRC_B_REG = 1'b0, SRC_B_IMM = 1'b1} srcBSelT;

endpackage

/* executeUnit.f */
common/execPkg.sv
alu/shifter.sv
alu/alu.sv
hw/opDecoder.sv
hw/operandStage.sv
hw/resultStage.sv
hw/executeUnit.sv
bench/executeUnitTb.sv

/* hw/executeUnit.sv */
// Execute stage top
// Decoder, operand register, ALU and result register.
// Fixed two-cycle latency, one instruction per cycle
`timescale 1ns/1ps

module executeUnit #(
  parameter int WIDTH = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             inValid,
  input  logic [6:0]       opcode,
  input  logic [2:0]       funct3,
  input  logic [6:0]       funct7,
  input  logic [WIDTH-1:0] rs1Val,
  input  logic [WIDTH-1:0] rs2Val,
  input  logic [WIDTH-1:0] imm,
  input  logic [WIDTH-1:0] pc,
  output logic             outValid,
  output logic [WIDTH-1:0] outResult,
  output logic [WIDTH-1:0] outSum,
  output logic             outIllegal
);

  // Decode outputs
  execPkg::aluCtrlT aluCtrl;
  execPkg::srcASelT srcASel;
  execPkg::srcBSelT srcBSel;
  logic             illegal;

  // Operand stage outputs
  logic             opValid;
  logic [WIDTH-1:0] opA;
  logic [WIDTH-1:0] opB;
  execPkg::aluCtrlT opCtrl;
  logic [2:0]       opFunct3;
  logic [6:0]       opFunct7;
  logic             opIllegal;

  // ALU outputs
  logic [WIDTH-1:0] aluResult;
  logic [WIDTH-1:0] aluSum;

  opDecoder #(.WIDTH(WIDTH)) dec (
    .opcode  (opcode),
    .funct3  (funct3),
    .funct7  (funct7),
    .aluCtrl (aluCtrl),
    .srcASel (srcASel),
    .srcBSel (srcBSel),
    .illegal (illegal)
  );

  operandStage #(.WIDTH(WIDTH)) opStage (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .rs1Val    (rs1Val),
    .rs2Val    (rs2Val),
    .imm       (imm),
    .pc        (pc),
    .srcASel   (srcASel),
    .srcBSel   (srcBSel),
    .aluCtrl   (aluCtrl),
    .funct3    (funct3),
    .funct7    (funct7),
    .illegal   (illegal),
    .opValid   (opValid),
    .opA       (opA),
    .opB       (opB),
    .opCtrl    (opCtrl),
    .opFunct3  (opFunct3),
    .opFunct7  (opFunct7),
    .opIllegal (opIllegal)
  );

  alu #(.WIDTH(WIDTH)) aluInst (
    .a       (opA),
    .b       (opB),
    .aluCtrl (opCtrl),
    .funct3  (opFunct3),
    .funct7  (opFunct7),
    .result  (aluResult),
    .sum     (aluSum)
  );

  resultStage #(.WIDTH(WIDTH)) resStage (
    .clk        (clk),
    .rst        (rst),
    .opValid    (opValid),
    .result     (aluResult),
    .sum        (aluSum),
    .opIllegal  (opIllegal),
    .outValid   (outValid),
    .outResult  (outResult),
    .outSum     (outSum),
    .outIllegal (outIllegal)
  );

endmodule

/* hw/opDecoder.sv */
// Instruction decoder for the execute stage
// Maps opcode, funct3 and funct7 to ALU controls and operand selects,
// and flags anything not in RV32I/RV64I integer ALU space as illegal
`timescale 1ns/1ps

module opDecoder #(
  parameter int WIDTH = 64
) (
  input  logic [6:0]       opcode,
  input  logic [2:0]       funct3,
  input  logic [6:0]       funct7,
  output execPkg::aluCtrlT aluCtrl,
  output execPkg::srcASelT srcASel,
  output execPkg::srcBSelT srcBSel,
  output logic             illegal
);

  logic rv64;      // W-type opcodes exist
  logic isCmp;     // slt/sltu need A - B
  logic f7Zero;    // funct7 = 0000000
  logic f7Alt;     // funct7 = 0100000, sub/sra
  logic shImmZero; // slli/srli, low funct7 bit is shamt[5]
  logic shImmAlt;  // srai

  assign rv64   = (WIDTH == 64);
  assign isCmp  = (funct3 == execPkg::F3_SLT) || (funct3 == execPkg::F3_SLTU);
  assign f7Zero = (funct7 == 7'b0000000);
  assign f7Alt  = (funct7 == 7'b0100000);
  // shamt[5] only legal on RV64
  assign shImmZero = (funct7[6:1] == 6'b000000) && (rv64 || !funct7[0]);
  assign shImmAlt  = (funct7[6:1] == 6'b010000) && (rv64 || !funct7[0]);

  always_comb begin
    aluCtrl = '0;                   // Defaults: add, reg operands
    srcASel = execPkg::SRC_A_REG;
    srcBSel = execPkg::SRC_B_REG;
    illegal = 1'b0;
    case (opcode)
      execPkg::OP_REG: begin
        aluCtrl.aluOp = 1'b1;
        if (f7Alt) begin          // sub or sra only
          aluCtrl.subArith = 1'b1;
          illegal = !((funct3 == execPkg::F3_ADD) || (funct3 == execPkg::F3_SR));
        end else begin
          aluCtrl.subArith = isCmp;
          illegal = !f7Zero;
        end
      end
      execPkg::OP_IMM: begin
        aluCtrl.aluOp = 1'b1;
        srcBSel = execPkg::SRC_B_IMM;
        case (funct3)
          execPkg::F3_SLL: illegal = !shImmZero;
          execPkg::F3_SR: begin
            aluCtrl.subArith = shImmAlt; // srai
            illegal = !(shImmZero || shImmAlt);
          end
          default: aluCtrl.subArith = isCmp; // slti/sltiu compare
        endcase
      end
      execPkg::OP_REG32: begin
        aluCtrl.w64      = rv64;   // never set on RV32
        aluCtrl.aluOp    = 1'b1;
        aluCtrl.subArith = f7Alt;  // subw, sraw
        case (funct3)
          execPkg::F3_ADD: illegal = !(f7Zero || f7Alt);
          execPkg::F3_SLL: illegal = !f7Zero;
          execPkg::F3_SR:  illegal = !(f7Zero || f7Alt);
          default:         illegal = 1'b1;
        endcase
        if (!rv64) illegal = 1'b1;
      end
      execPkg::OP_IMM32: begin
        aluCtrl.w64   = rv64;
        aluCtrl.aluOp = 1'b1;
        srcBSel = execPkg::SRC_B_IMM;
        case (funct3)
          execPkg::F3_ADD: illegal = 1'b0; // addiw
          execPkg::F3_SLL: illegal = !f7Zero;
          execPkg::F3_SR: begin
            aluCtrl.subArith = f7Alt; // sraiw
            illegal = !(f7Zero || f7Alt);
          end
          default: illegal = 1'b1;
        endcase
        if (!rv64) illegal = 1'b1;
      end
      execPkg::OP_LOAD: begin     // Address generation
        srcBSel = execPkg::SRC_B_IMM;
        // ld/lwu only on RV64, 111 never
        illegal = (funct3 == 3'b111) || (!rv64 && ((funct3 == 3'b011) || (funct3 == 3'b110)));
      end
      execPkg::OP_STORE: begin
        srcBSel = execPkg::SRC_B_IMM;
        illegal = funct3[2] || (!rv64 && (funct3 == 3'b011)); // sd on RV64 only
      end
      execPkg::OP_AUIPC: begin
        srcASel = execPkg::SRC_A_PC;   // pc + imm
        srcBSel = execPkg::SRC_B_IMM;
      end
      execPkg::OP_LUI: begin
        srcASel = execPkg::SRC_A_ZERO; // 0 + imm
        srcBSel = execPkg::SRC_B_IMM;
      end
      default: illegal = 1'b1;         // Unknown opcode
    endcase
  end

endmodule

/* hw/operandStage.sv */
// Operand register stage
// Picks operands A and B from the decoded selects and captures them
// together with ALU controls and funct fields on each valid strobe
`timescale 1ns/1ps

module operandStage #(
  parameter int WIDTH = 64
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inValid,
  input  logic [WIDTH-1:0]       rs1Val,
  input  logic [WIDTH-1:0]       rs2Val,
  input  logic [WIDTH-1:0]       imm,
  input  logic [WIDTH-1:0]       pc,
  input  execPkg::srcASelT       srcASel,
  input  execPkg::srcBSelT       srcBSel,
  input  execPkg::aluCtrlT       aluCtrl,
  input  logic [2:0]             funct3,
  input  logic [6:0]             funct7,
  input  logic                   illegal,
  output logic                   opValid,
  output logic [WIDTH-1:0]       opA,
  output logic [WIDTH-1:0]       opB,
  output execPkg::aluCtrlT       opCtrl,
  output logic [2:0]             opFunct3,
  output logic [6:0]             opFunct7,
  output logic                   opIllegal
);

  logic [WIDTH-1:0] aSel; // Muxed A
  logic [WIDTH-1:0] bSel; // Muxed B

  always_comb begin
    case (srcASel)
      execPkg::SRC_A_PC:   aSel = pc;  // AUIPC
      execPkg::SRC_A_ZERO: aSel = '0;  // LUI
      default:             aSel = rs1Val;
    endcase
  end

  assign bSel = (srcBSel == execPkg::SRC_B_IMM) ? imm : rs2Val;

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      opValid   <= 1'b0;
      opIllegal <= 1'b0;
    end else begin
      opValid <= inValid;
      if (inValid) opIllegal <= illegal;
    end
  end

  // Payload, loads only on a strobe
  always_ff @(posedge clk) begin
    if (inValid) begin
      opA      <= aSel;
      opB      <= bSel;
      opCtrl   <= aluCtrl;
      opFunct3 <= funct3;
      opFunct7 <= funct7;
    end
  end

  // Strobe must be clean once out of reset
  assert property (@(posedge clk) disable iff (rst) !$isunknown(inValid))
    else $error("operandStage: inValid unknown");

endmodule

/* hw/resultStage.sv */
// Result register stage
// Holds ALU result, raw sum and the illegal flag for writeback
`timescale 1ns/1ps

module resultStage #(
  parameter int WIDTH = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             opValid,
  input  logic [WIDTH-1:0] result,
  input  logic [WIDTH-1:0] sum,
  input  logic             opIllegal,
  output logic             outValid,
  output logic [WIDTH-1:0] outResult,
  output logic [WIDTH-1:0] outSum,
  output logic             outIllegal
);

  // Valid and illegal travel together
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid   <= 1'b0;
      outIllegal <= 1'b0;
    end else begin
      outValid   <= opValid;
      outIllegal <= opValid & opIllegal; // Drops with the strobe
    end
  end

  always_ff @(posedge clk) begin
    if (opValid) begin
      outResult <= result;
      outSum    <= sum;
    end
  end

  // Legal beat must carry known ALU data
  assert property (@(posedge clk) disable iff (rst)
                   opValid && !opIllegal |-> !$isunknown({result, sum}))
    else $error("resultStage: result unknown on a legal beat");

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module executeUnitTb \
  -f executeUnit.f -o simExecuteUnit > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simExecuteUnit > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
exit 0
